/* verilog/rv_decode_pkg.sv */
package rv_decode_pkg;

    localparam int INSTR_W = 32;
    localparam int CTRL_W  = 35;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes and decoded classes
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [6:0] {
        OP_EMPTY   = 7'b0000000,    // All-zero word, decodes to a no-op
        OP_LOAD    = 7'b0000011,
        OP_ARITH_I = 7'b0010011,
        OP_AUIPC   = 7'b0010111,
        OP_STORE   = 7'b0100011,
        OP_ARITH_R = 7'b0110011,
        OP_LUI     = 7'b0110111,
        OP_BRANCH  = 7'b1100011,
        OP_JALR    = 7'b1100111,
        OP_JAL     = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        CLS_ARITH_R, CLS_ARITH_I, CLS_BRANCH, CLS_LOAD, CLS_STORE, CLS_JAL,
        CLS_JALR, CLS_AUIPC, CLS_LUI, CLS_EMPTY, CLS_ILLEGAL
    } op_class_t;

    ////////////////////////////////////////////////////////////////////////////
    // Control word fields
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [7:0] {
        // Base integer ALU
        SUB  = 8'h00, ADD    = 8'h01, AND    = 8'h02, OR     = 8'h03, XOR   = 8'h04,
        RMV  = 8'h05, LMV    = 8'h06, ARMV   = 8'h07, SLTS   = 8'h08, SLTUS = 8'h09,
        // B extension ALU
        ANDN = 8'h10, MAX    = 8'h11, MAXU   = 8'h12, MIN    = 8'h13, MINU  = 8'h14,
        ORN  = 8'h15, SH1ADD = 8'h16, SH2ADD = 8'h17, SH3ADD = 8'h18, XNOR  = 8'h19,
        // Bit count and rotate
        BCLR = 8'h30, BEXT   = 8'h31, BINV   = 8'h32, BSET   = 8'h33, CLZ   = 8'h34,
        CPOP = 8'h35, CTZ    = 8'h36, ROL    = 8'h37, ROR    = 8'h38, ROLI  = 8'h39,
        RORI = 8'h3A,
        // Multiply and divide, low bits follow funct3
        MUL  = 8'h40, MULH   = 8'h41, MULHSU = 8'h42, MULHU  = 8'h43,
        DIV  = 8'h44, DIVU   = 8'h45, REM    = 8'h46, REMU   = 8'h47
    } ccu_mode_t;

    typedef enum logic [3:0] {
        NPC = 4'h0, OFFPC = 4'h1, NEQ = 4'h2, EQ  = 4'h3, SLT = 4'h4,
        ULT = 4'h5, SGT   = 4'h6, UGT = 4'h7, JALR = 4'h8
    } jump_ctrl_t;

    typedef enum logic [2:0] {
        BY_WORD = 3'h0, BY_HALF = 3'h1, BY_HALF_U = 3'h2, BY_BYTE = 3'h3, BY_BYTE_U = 3'h4
    } dmu_mode_t;

    typedef enum logic [2:0] {SR1_REG = 3'b000, SR1_PC = 3'b001, SR1_ZERO = 3'b011} sr1_sel_t;
    typedef enum logic [2:0] {SR2_REG = 3'b000, SR2_IMM = 3'b001, SR2_ZERO = 3'b011} sr2_sel_t;

    typedef enum logic [2:0] {
        RF_CCU = 3'b000, RF_PCP4 = 3'b001, RF_DMU = 3'b010, RF_ZERO = 3'b110
    } rf_wb_sel_t;

    // Bit 34 down to bit 0
    typedef struct packed {
        logic        ebreak;        // Tied low
        jump_ctrl_t  jump_ctrl;
        logic        csr_we;        // Tied low
        logic        dm_rd;
        logic        dm_we;
        dmu_mode_t   dmu_mode;
        logic        rsvd_23;
        logic        rfi_we;
        ccu_mode_t   ccu_mode;
        logic [1:0]  rsvd_13_12;
        logic        ccu_ans_sel;   // High selects the MDU result
        logic        rf_sr2_sel;
        logic        rf_sr1_sel;
        rf_wb_sel_t  rf_wb_sel;
        sr2_sel_t    sr2_sel;
        sr1_sel_t    sr1_sel;
    } ctrl_word_t;

endpackage

/* verilog/decode_if.sv */
`timescale 1ns/1ps

// Stage 1 to stage 2, plain valid strobe with no back-pressure
interface decode_if;
    logic                     valid;
    rv_decode_pkg::op_class_t op_class;
    logic [2:0]               funct3;
    rv_decode_pkg::ccu_mode_t ccu_mode;
    logic                     ccu_ans_sel;

    modport producer (
        output valid,
        output op_class,
        output funct3,
        output ccu_mode,
        output ccu_ans_sel
    );

    modport consumer (
        input valid,
        input op_class,
        input funct3,
        input ccu_mode,
        input ccu_ans_sel
    );
endinterface

/* verilog/alu_mode_decoder.sv */
`timescale 1ns/1ps

module alu_mode_decoder (
    input  rv_decode_pkg::op_class_t op_class,
    input  logic [6:0]               funct7,
    input  logic [2:0]               funct3,
    input  logic [4:0]               rs2_field,
    output rv_decode_pkg::ccu_mode_t ccu_mode,
    output logic                     ccu_ans_sel
);

    // Base integer group, shared by register and immediate forms
    function automatic rv_decode_pkg::ccu_mode_t base_mode(input logic [2:0] f3);
        case (f3)
            3'b000:  return rv_decode_pkg::ADD;
            3'b001:  return rv_decode_pkg::LMV;
            3'b010:  return rv_decode_pkg::SLTS;
            3'b011:  return rv_decode_pkg::SLTUS;
            3'b100:  return rv_decode_pkg::XOR;
            3'b101:  return rv_decode_pkg::RMV;
            3'b110:  return rv_decode_pkg::OR;
            default: return rv_decode_pkg::AND;
        endcase
    endfunction

    always_comb begin
        ccu_mode    = rv_decode_pkg::ADD;   // Anything not listed below
        ccu_ans_sel = 1'b0;

        case (op_class)
            rv_decode_pkg::CLS_ARITH_R: begin
                case (funct7)
                    7'b0000000: ccu_mode = base_mode(funct3);
                    7'b0100000: begin
                        case (funct3)
                            3'b000:  ccu_mode = rv_decode_pkg::SUB;
                            3'b100:  ccu_mode = rv_decode_pkg::XNOR;
                            3'b101:  ccu_mode = rv_decode_pkg::ARMV;
                            3'b110:  ccu_mode = rv_decode_pkg::ORN;
                            3'b111:  ccu_mode = rv_decode_pkg::ANDN;
                            default: ccu_mode = rv_decode_pkg::ADD;
                        endcase
                    end
                    7'b0010000: begin       // Shift then add
                        case (funct3)
                            3'b010:  ccu_mode = rv_decode_pkg::SH1ADD;
                            3'b100:  ccu_mode = rv_decode_pkg::SH2ADD;
                            3'b110:  ccu_mode = rv_decode_pkg::SH3ADD;
                            default: ccu_mode = rv_decode_pkg::ADD;
                        endcase
                    end
                    7'b0000101: begin       // Min and max
                        case (funct3)
                            3'b100:  ccu_mode = rv_decode_pkg::MIN;
                            3'b101:  ccu_mode = rv_decode_pkg::MINU;
                            3'b110:  ccu_mode = rv_decode_pkg::MAX;
                            3'b111:  ccu_mode = rv_decode_pkg::MAXU;
                            default: ccu_mode = rv_decode_pkg::ADD;
                        endcase
                    end
                    7'b0110000: begin       // Rotates
                        if (funct3 == 3'b001)
                            ccu_mode = rv_decode_pkg::ROL;
                        else if (funct3 == 3'b101)
                            ccu_mode = rv_decode_pkg::ROR;
                    end
                    7'b0000001: begin
                        // MUL through REMU sit at 8'h40 plus funct3
                        ccu_ans_sel = 1'b1;
                        ccu_mode    = rv_decode_pkg::ccu_mode_t'({5'b01000, funct3});
                    end
                    default: ccu_mode = rv_decode_pkg::ADD;
                endcase
            end

            rv_decode_pkg::CLS_ARITH_I: begin
                if (funct7 == 7'b0110000) begin
                    // Counts pick their operation in the rs2 slot
                    if (funct3 == 3'b101)
                        ccu_mode = rv_decode_pkg::RORI;
                    else if (funct3 == 3'b001 && rs2_field == 5'b00000)
                        ccu_mode = rv_decode_pkg::CLZ;
                    else if (funct3 == 3'b001 && rs2_field == 5'b00001)
                        ccu_mode = rv_decode_pkg::CTZ;
                    else if (funct3 == 3'b001 && rs2_field == 5'b00010)
                        ccu_mode = rv_decode_pkg::CPOP;
                end else if (funct3 == 3'b101) begin
                    ccu_mode = funct7[5] ? rv_decode_pkg::ARMV : rv_decode_pkg::RMV;  // srai
                end else begin
                    ccu_mode = base_mode(funct3);
                end
            end

            rv_decode_pkg::CLS_BRANCH: ccu_mode = rv_decode_pkg::SUB;   // Compare by subtract
            default: ccu_mode = rv_decode_pkg::ADD;
        endcase
    end

endmodule

/* verilog/instr_classifier.sv */
`timescale 1ns/1ps

module instr_classifier (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [rv_decode_pkg::INSTR_W-1:0] instr,
    input  logic                              instr_valid,
    decode_if.producer                        dec
);

    rv_decode_pkg::op_class_t op_class;
    rv_decode_pkg::ccu_mode_t ccu_mode;
    logic                     ccu_ans_sel;

    always_comb begin
        case (instr[6:0])
            rv_decode_pkg::OP_ARITH_R: op_class = rv_decode_pkg::CLS_ARITH_R;
            rv_decode_pkg::OP_ARITH_I: op_class = rv_decode_pkg::CLS_ARITH_I;
            rv_decode_pkg::OP_BRANCH:  op_class = rv_decode_pkg::CLS_BRANCH;
            rv_decode_pkg::OP_LOAD:    op_class = rv_decode_pkg::CLS_LOAD;
            rv_decode_pkg::OP_STORE:   op_class = rv_decode_pkg::CLS_STORE;
            rv_decode_pkg::OP_JAL:     op_class = rv_decode_pkg::CLS_JAL;
            rv_decode_pkg::OP_JALR:    op_class = rv_decode_pkg::CLS_JALR;
            rv_decode_pkg::OP_AUIPC:   op_class = rv_decode_pkg::CLS_AUIPC;
            rv_decode_pkg::OP_LUI:     op_class = rv_decode_pkg::CLS_LUI;
            rv_decode_pkg::OP_EMPTY:   op_class = rv_decode_pkg::CLS_EMPTY;
            default:                   op_class = rv_decode_pkg::CLS_ILLEGAL;  // System too
        endcase
    end

    alu_mode_decoder u_alu_mode_decoder (
        .op_class    (op_class),
        .funct7      (instr[31:25]),
        .funct3      (instr[14:12]),
        .rs2_field   (instr[24:20]),
        .ccu_mode    (ccu_mode),
        .ccu_ans_sel (ccu_ans_sel)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1 registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            dec.valid <= 1'b0;
        else
            dec.valid <= instr_valid;
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin      // Hold payload between instructions
            dec.op_class    <= op_class;
            dec.funct3      <= instr[14:12];
            dec.ccu_mode    <= ccu_mode;
            dec.ccu_ans_sel <= ccu_ans_sel;
        end
    end

    a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(dec.valid));

endmodule

/* verilog/ctrl_word_gen.sv */
`timescale 1ns/1ps

module ctrl_word_gen (
    input  logic                      clk,
    input  logic                      arst_n,
    decode_if.consumer                dec,
    output rv_decode_pkg::ctrl_word_t control_signals,
    output logic                      ctrl_valid,
    output logic                      error
);

    rv_decode_pkg::ctrl_word_t word;
    logic                      illegal;

    always_comb begin
        word             = '0;
        word.jump_ctrl   = rv_decode_pkg::NPC;
        word.dmu_mode    = rv_decode_pkg::BY_WORD;
        word.sr1_sel     = rv_decode_pkg::SR1_ZERO;
        word.sr2_sel     = rv_decode_pkg::SR2_ZERO;
        word.rf_wb_sel   = rv_decode_pkg::RF_ZERO;
        word.ccu_mode    = dec.ccu_mode;       // ADD outside the ALU classes
        word.ccu_ans_sel = dec.ccu_ans_sel;
        illegal          = 1'b0;

        case (dec.op_class)
            rv_decode_pkg::CLS_ARITH_R: begin
                word.sr1_sel   = rv_decode_pkg::SR1_REG;
                word.sr2_sel   = rv_decode_pkg::SR2_REG;
                word.rf_wb_sel = rv_decode_pkg::RF_CCU;
                word.rfi_we    = 1'b1;
            end
            rv_decode_pkg::CLS_ARITH_I, rv_decode_pkg::CLS_AUIPC, rv_decode_pkg::CLS_LUI: begin
                word.sr1_sel   = rv_decode_pkg::SR1_REG;
                word.sr2_sel   = rv_decode_pkg::SR2_IMM;
                word.rf_wb_sel = rv_decode_pkg::RF_CCU;
                word.rfi_we    = 1'b1;
                if (dec.op_class == rv_decode_pkg::CLS_AUIPC)
                    word.sr1_sel = rv_decode_pkg::SR1_PC;
                else if (dec.op_class == rv_decode_pkg::CLS_LUI)
                    word.sr1_sel = rv_decode_pkg::SR1_ZERO;   // Immediate passes through
            end
            rv_decode_pkg::CLS_BRANCH: begin
                case (dec.funct3)
                    3'b001:  word.jump_ctrl = rv_decode_pkg::NEQ;
                    3'b100:  word.jump_ctrl = rv_decode_pkg::SLT;
                    3'b101:  word.jump_ctrl = rv_decode_pkg::SGT;
                    3'b110:  word.jump_ctrl = rv_decode_pkg::ULT;
                    3'b111:  word.jump_ctrl = rv_decode_pkg::UGT;
                    default: word.jump_ctrl = rv_decode_pkg::EQ;  // beq and reserved codes
                endcase
            end
            rv_decode_pkg::CLS_LOAD: begin
                word.sr1_sel   = rv_decode_pkg::SR1_REG;
                word.sr2_sel   = rv_decode_pkg::SR2_IMM;
                word.rf_wb_sel = rv_decode_pkg::RF_DMU;
                word.rfi_we    = 1'b1;
                word.dm_rd     = 1'b1;
                case (dec.funct3)
                    3'b000:  word.dmu_mode = rv_decode_pkg::BY_BYTE;
                    3'b001:  word.dmu_mode = rv_decode_pkg::BY_HALF;
                    3'b100:  word.dmu_mode = rv_decode_pkg::BY_BYTE_U;
                    3'b101:  word.dmu_mode = rv_decode_pkg::BY_HALF_U;
                    default: word.dmu_mode = rv_decode_pkg::BY_WORD;
                endcase
            end
            rv_decode_pkg::CLS_STORE: begin
                word.sr1_sel = rv_decode_pkg::SR1_REG;
                word.sr2_sel = rv_decode_pkg::SR2_IMM;
                word.dm_we   = 1'b1;
            end
            rv_decode_pkg::CLS_JAL, rv_decode_pkg::CLS_JALR: begin
                word.rf_wb_sel = rv_decode_pkg::RF_PCP4;   // Link address
                word.rfi_we    = 1'b1;
                word.jump_ctrl = rv_decode_pkg::OFFPC;
                if (dec.op_class == rv_decode_pkg::CLS_JALR) begin
                    word.sr1_sel   = rv_decode_pkg::SR1_REG;
                    word.sr2_sel   = rv_decode_pkg::SR2_IMM;
                    word.jump_ctrl = rv_decode_pkg::JALR;
                end
            end
            rv_decode_pkg::CLS_ILLEGAL: illegal = 1'b1;
            default: ;                                  // Empty opcode
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2 registers, outputs hold while idle
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            control_signals <= '0;
            ctrl_valid      <= 1'b0;
            error           <= 1'b0;
        end else begin
            ctrl_valid <= dec.valid;
            if (dec.valid) begin
                control_signals <= word;
                error           <= illegal;
            end
        end
    end

    a_mem_excl: assert property (@(posedge clk) disable iff (!arst_n)
        ctrl_valid |-> !(control_signals.dm_we && control_signals.dm_rd));

    // Illegal class from stage 1 must come out as a flagged, write-free word
    a_err_no_wr: assert property (@(posedge clk) disable iff (!arst_n)
        dec.valid && dec.op_class == rv_decode_pkg::CLS_ILLEGAL
        |=> error && !control_signals.rfi_we && !control_signals.dm_we);

endmodule

/* verilog/decoder_top.sv */
`timescale 1ns/1ps

module decoder_top (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [rv_decode_pkg::INSTR_W-1:0] instr,
    input  logic                              instr_valid,
    output logic [rv_decode_pkg::CTRL_W-1:0]  control_signals,
    output logic                              ctrl_valid,
    output logic                              error
);

    decode_if dec_if ();

    instr_classifier u_instr_classifier (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .dec         (dec_if.producer)
    );

    ctrl_word_gen u_ctrl_word_gen (
        .clk             (clk),
        .arst_n          (arst_n),
        .dec             (dec_if.consumer),
        .control_signals (control_signals),
        .ctrl_valid      (ctrl_valid),
        .error           (error)
    );

endmodule

/* include/ctrl_model.svh */
`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

function automatic rv_decode_pkg::ccu_mode_t ctrl_model_base(input logic [2:0] f3);
    rv_decode_pkg::ccu_mode_t tbl [8];
    tbl = '{rv_decode_pkg::ADD, rv_decode_pkg::LMV, rv_decode_pkg::SLTS, rv_decode_pkg::SLTUS,
            rv_decode_pkg::XOR, rv_decode_pkg::RMV, rv_decode_pkg::OR, rv_decode_pkg::AND};
    return tbl[f3];
endfunction

// Expected {error, control word} for one instruction
function automatic logic [rv_decode_pkg::CTRL_W:0] ctrl_model(input logic [31:0] instr);
    rv_decode_pkg::ctrl_word_t w;
    logic                      err;
    logic [6:0]                f7;
    logic [2:0]                f3;
    f7          = instr[31:25];
    f3          = instr[14:12];
    w           = '0;
    err         = 1'b0;
    w.sr1_sel   = rv_decode_pkg::SR1_ZERO;
    w.sr2_sel   = rv_decode_pkg::SR2_ZERO;
    w.rf_wb_sel = rv_decode_pkg::RF_ZERO;
    w.ccu_mode  = rv_decode_pkg::ADD;
    case (instr[6:0])
        7'b0110011: begin
            {w.sr1_sel, w.sr2_sel} = {rv_decode_pkg::SR1_REG, rv_decode_pkg::SR2_REG};
            {w.rf_wb_sel, w.rfi_we} = {rv_decode_pkg::RF_CCU, 1'b1};
            if (f7 == 7'b0000001) begin
                w.ccu_ans_sel = 1'b1;
                case (f3)
                    3'b000:  w.ccu_mode = rv_decode_pkg::MUL;
                    3'b001:  w.ccu_mode = rv_decode_pkg::MULH;
                    3'b010:  w.ccu_mode = rv_decode_pkg::MULHSU;
                    3'b011:  w.ccu_mode = rv_decode_pkg::MULHU;
                    3'b100:  w.ccu_mode = rv_decode_pkg::DIV;
                    3'b101:  w.ccu_mode = rv_decode_pkg::DIVU;
                    3'b110:  w.ccu_mode = rv_decode_pkg::REM;
                    default: w.ccu_mode = rv_decode_pkg::REMU;
                endcase
            end else if (f7 == 7'b0000000) begin
                w.ccu_mode = ctrl_model_base(f3);
            end else begin
                case ({f7, f3})
                    10'b0100000_000: w.ccu_mode = rv_decode_pkg::SUB;
                    10'b0100000_100: w.ccu_mode = rv_decode_pkg::XNOR;
                    10'b0100000_101: w.ccu_mode = rv_decode_pkg::ARMV;
                    10'b0100000_110: w.ccu_mode = rv_decode_pkg::ORN;
                    10'b0100000_111: w.ccu_mode = rv_decode_pkg::ANDN;
                    10'b0010000_010: w.ccu_mode = rv_decode_pkg::SH1ADD;
                    10'b0010000_100: w.ccu_mode = rv_decode_pkg::SH2ADD;
                    10'b0010000_110: w.ccu_mode = rv_decode_pkg::SH3ADD;
                    10'b0000101_100: w.ccu_mode = rv_decode_pkg::MIN;
                    10'b0000101_101: w.ccu_mode = rv_decode_pkg::MINU;
                    10'b0000101_110: w.ccu_mode = rv_decode_pkg::MAX;
                    10'b0000101_111: w.ccu_mode = rv_decode_pkg::MAXU;
                    10'b0110000_001: w.ccu_mode = rv_decode_pkg::ROL;
                    10'b0110000_101: w.ccu_mode = rv_decode_pkg::ROR;
                    default:         w.ccu_mode = rv_decode_pkg::ADD;
                endcase
            end
        end
        7'b0010011: begin
            {w.sr1_sel, w.sr2_sel} = {rv_decode_pkg::SR1_REG, rv_decode_pkg::SR2_IMM};
            {w.rf_wb_sel, w.rfi_we} = {rv_decode_pkg::RF_CCU, 1'b1};
            if (f7 == 7'b0110000) begin
                case ({f3, instr[24:20]})
                    8'b001_00000: w.ccu_mode = rv_decode_pkg::CLZ;
                    8'b001_00001: w.ccu_mode = rv_decode_pkg::CTZ;
                    8'b001_00010: w.ccu_mode = rv_decode_pkg::CPOP;
                    default: if (f3 == 3'b101) w.ccu_mode = rv_decode_pkg::RORI;
                endcase
            end else if (f3 == 3'b101) begin
                w.ccu_mode = f7[5] ? rv_decode_pkg::ARMV : rv_decode_pkg::RMV;
            end else begin
                w.ccu_mode = ctrl_model_base(f3);
            end
        end
        7'b1100011: begin
            w.ccu_mode = rv_decode_pkg::SUB;
            case (f3)
                3'b001:  w.jump_ctrl = rv_decode_pkg::NEQ;
                3'b100:  w.jump_ctrl = rv_decode_pkg::SLT;
                3'b101:  w.jump_ctrl = rv_decode_pkg::SGT;
                3'b110:  w.jump_ctrl = rv_decode_pkg::ULT;
                3'b111:  w.jump_ctrl = rv_decode_pkg::UGT;
                default: w.jump_ctrl = rv_decode_pkg::EQ;
            endcase
        end
        7'b0000011: begin
            {w.sr1_sel, w.sr2_sel} = {rv_decode_pkg::SR1_REG, rv_decode_pkg::SR2_IMM};
            {w.rf_wb_sel, w.rfi_we, w.dm_rd} = {rv_decode_pkg::RF_DMU, 2'b11};
            case (f3)
                3'b000:  w.dmu_mode = rv_decode_pkg::BY_BYTE;
                3'b001:  w.dmu_mode = rv_decode_pkg::BY_HALF;
                3'b100:  w.dmu_mode = rv_decode_pkg::BY_BYTE_U;
                3'b101:  w.dmu_mode = rv_decode_pkg::BY_HALF_U;
                default: w.dmu_mode = rv_decode_pkg::BY_WORD;
            endcase
        end
        7'b0100011: begin
            {w.sr1_sel, w.sr2_sel} = {rv_decode_pkg::SR1_REG, rv_decode_pkg::SR2_IMM};
            w.dm_we = 1'b1;
        end
        7'b1101111: begin
            {w.rf_wb_sel, w.rfi_we} = {rv_decode_pkg::RF_PCP4, 1'b1};
            w.jump_ctrl = rv_decode_pkg::OFFPC;
        end
        7'b1100111: begin
            {w.sr1_sel, w.sr2_sel} = {rv_decode_pkg::SR1_REG, rv_decode_pkg::SR2_IMM};
            {w.rf_wb_sel, w.rfi_we} = {rv_decode_pkg::RF_PCP4, 1'b1};
            w.jump_ctrl = rv_decode_pkg::JALR;
        end
        7'b0010111, 7'b0110111: begin
            w.sr1_sel = instr[5] ? rv_decode_pkg::SR1_ZERO : rv_decode_pkg::SR1_PC;  // lui
            w.sr2_sel = rv_decode_pkg::SR2_IMM;
            {w.rf_wb_sel, w.rfi_we} = {rv_decode_pkg::RF_CCU, 1'b1};
        end
        7'b0000000: ;
        default: err = 1'b1;
    endcase
    return {err, w};
endfunction

`endif

/* tb/decoder_tb.sv */
`timescale 1ns/1ps

module decoder_tb;

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 16;
    localparam int NUM_CYCLES = 3000;

    logic        clk;
    logic        arst_n;
    logic [31:0] instr;
    logic        instr_valid;
    logic [34:0] control_signals;
    logic        ctrl_valid;
    logic        error;

    logic [31:0] seed = 32'h6810;
    logic [35:0] exp_q [$];      // {error, control word} in issue order
    logic [63:0] issue_q [$];    // Drive time of each queued instruction
    logic [35:0] last_exp = '0;  // Reset values until the first output
    int          n_checked = 0;

    `include "ctrl_model.svh"

    decoder_top uut (
        .clk             (clk),
        .arst_n          (arst_n),
        .instr           (instr),
        .instr_valid     (instr_valid),
        .control_signals (control_signals),
        .ctrl_valid      (ctrl_valid),
        .error           (error)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Clock, random source, helpers
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [6:0] pick_opcode(input int idx);
        case (idx)
            0:       return rv_decode_pkg::OP_LOAD;
            1:       return rv_decode_pkg::OP_ARITH_I;
            2:       return rv_decode_pkg::OP_AUIPC;
            3:       return rv_decode_pkg::OP_STORE;
            4:       return rv_decode_pkg::OP_ARITH_R;
            5:       return rv_decode_pkg::OP_LUI;
            6:       return rv_decode_pkg::OP_BRANCH;
            7:       return rv_decode_pkg::OP_JALR;
            8:       return rv_decode_pkg::OP_JAL;
            9:       return rv_decode_pkg::OP_EMPTY;
            default: return 7'b1110011;        // System opcode, now illegal
        endcase
    endfunction

    task automatic check_value(input string name, input logic [35:0] expected,
                               input logic [35:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    // Funct7 biased toward the decoded groups, rs2 toward the count codes
    task automatic build_instr(output logic [31:0] word);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [6:0]  f7;
        logic [4:0]  rs2;
        int          idx;
        seed = lcg_next(seed);
        r1   = seed;
        seed = lcg_next(seed);
        r2   = seed;
        seed = lcg_next(seed);
        r3   = seed;
        idx  = int'(r1[27:16]) % 11;
        case (r1[15:13])
            3'd0:    f7 = 7'b0000000;
            3'd1:    f7 = 7'b0100000;
            3'd2:    f7 = 7'b0010000;
            3'd3:    f7 = 7'b0000101;
            3'd4:    f7 = 7'b0110000;
            3'd5:    f7 = 7'b0000001;
            default: f7 = r2[31:25];
        endcase
        rs2 = r1[12] ? {3'b000, r1[11:10]} : r2[24:20];
        if (r1[31:28] == 4'h0)
            word = r2 ^ {r3[15:0], r3[31:16]};   // Fully random word
        else
            word = {f7, rs2, r2[19:15], r3[30:28], r2[11:7], pick_opcode(idx)};
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and end of run
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] word;
        instr       = '0;
        instr_valid = 1'b0;
        arst_n      = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        @(negedge clk);
        check_value("reset ctrl_valid", 36'd0, {35'd0, ctrl_valid});
        check_value("reset error", 36'd0, {35'd0, error});
        check_value("reset control_signals", 36'd0, {1'b0, control_signals});

        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(posedge clk);
            seed = lcg_next(seed);
            if (seed[31:30] != 2'b00) begin     // About 3 in 4 cycles
                build_instr(word);
                instr       <= word;
                instr_valid <= 1'b1;
                exp_q.push_back(ctrl_model(word));
                issue_q.push_back($time);
            end else begin
                instr_valid <= 1'b0;
            end
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        repeat (4) @(posedge clk);   // Drain the two stages
        @(negedge clk);

        if (exp_q.size() != 0) begin
            $display("%0d instructions never came out of the decoder", exp_q.size());
            $display("FAIL: see errors above");
            $fatal(1);
        end else begin
            $display("%0d control words checked", n_checked);
            $display("PASS: all tests");
            $finish;
        end
    end

    // Outputs settle after the rising edge, compare on the falling one
    always @(negedge clk) begin
        logic [35:0]               exp;
        logic [63:0]               issued;
        rv_decode_pkg::ctrl_word_t cw;
        if (arst_n && ctrl_valid) begin
            if (exp_q.size() == 0) begin
                $display("ctrl_valid went high with no instruction outstanding");
                $display("FAIL: see errors above");
                $fatal(1);
            end else begin
                exp    = exp_q.pop_front();
                issued = issue_q.pop_front();
                cw     = control_signals;
                n_checked++;
                // Sampled one edge after the drive, out two edges later
                check_value($sformatf("latency #%0d", n_checked),
                            36'(issued + 2 * CLK_PERIOD + CLK_PERIOD / 2), 36'($time));
                check_value("dm_we and dm_rd exclusive", 36'd0,
                            {35'd0, cw.dm_we & cw.dm_rd});
                check_value($sformatf("control_signals #%0d", n_checked),
                            {1'b0, exp[34:0]}, {1'b0, control_signals});
                check_value($sformatf("error #%0d", n_checked),
                            {35'd0, exp[35]}, {35'd0, error});
                last_exp = exp;
            end
        end else if (arst_n) begin
            check_value("outputs hold while ctrl_valid is low", last_exp,
                        {error, control_signals});
        end
    end

    initial begin
        #((RST_CYCLES + NUM_CYCLES + 100) * CLK_PERIOD);
        $display("Timeout, the run did not finish in time");
        $display("FAIL: see errors above");
        $fatal(1);
    end

endmodule

/* rv_decoder.f */
+incdir+include
verilog/rv_decode_pkg.sv
verilog/decode_if.sv
verilog/alu_mode_decoder.sv
verilog/instr_classifier.sv
verilog/ctrl_word_gen.sv
verilog/decoder_top.sv
tb/decoder_tb.sv

/* Makefile */
SIM := obj_dir/Vdecoder_tb

.PHONY: compile run clean

compile: $(SIM)

$(SIM): rv_decoder.f verilog/*.sv tb/*.sv include/*.svh
	verilator --binary --timing --assert -sv -f rv_decoder.f \
		--top-module decoder_tb -Mdir obj_dir

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
